// File: rtl/router_defs.svh
`ifndef ROUTER_DEFS_SVH
`define ROUTER_DEFS_SVH

// Link geometry. Ports are numbered L, N, E, W, S from zero.
`define ROUTER_NUM_PORTS 5

// Flit fields. A flit id of 1 marks a header, 2 a body flit and 3 a tail.
`define ROUTER_FLIT_ID_W 3
`define ROUTER_LENGTH_W 12
`define ROUTER_DATA_W 16

// Entries held by each input FIFO.
`define ROUTER_FIFO_DEPTH 4

`endif

// File: rtl/routerPkg.sv
`include "router_defs.svh"

package routerPkg;

  typedef logic [`ROUTER_FLIT_ID_W-1:0] flitIdT;

  // Grant budget in flits, taken from the header length field.
  typedef logic [`ROUTER_LENGTH_W-1:0] flitLengthT;

  typedef logic [`ROUTER_DATA_W-1:0] flitDataT;

  // Port number, 0 to 4 for L, N, E, W and S.
  typedef logic [$clog2(`ROUTER_NUM_PORTS)-1:0] portIdxT;

  // One bit per port, bit 0 is L.
  typedef logic [`ROUTER_NUM_PORTS-1:0] portMaskT;

  // One-hot arbiter state. Bit 0 is idle, bits 1 to 5 grant L, N, E, W, S.
  typedef enum logic [`ROUTER_NUM_PORTS:0] {
    idle   = 6'b000001,
    grantL = 6'b000010,
    grantN = 6'b000100,
    grantE = 6'b001000,
    grantW = 6'b010000,
    grantS = 6'b100000
  } arbStateT;

endpackage

// File: rtl/inputPort.sv
`timescale 1ns/1ns
`include "router_defs.svh"

module inputPort (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wrEn,
  input  routerPkg::flitIdT     wrFlitId,
  input  routerPkg::flitLengthT wrLength,
  input  routerPkg::flitDataT   wrData,
  input  logic                  grant,
  output logic                  full,
  output logic                  req,
  output routerPkg::flitIdT     headFlitId,
  output routerPkg::flitLengthT headLength,
  output routerPkg::flitDataT   headData
);

  localparam int Depth = `ROUTER_FIFO_DEPTH;
  localparam int PtrW = $clog2(Depth);
  localparam int CountW = $clog2(Depth + 1);

  routerPkg::flitIdT     idMem     [Depth];
  routerPkg::flitLengthT lengthMem [Depth];
  routerPkg::flitDataT   dataMem   [Depth];

  logic [PtrW-1:0]   wrPtr;
  logic [PtrW-1:0]   rdPtr;
  logic [CountW-1:0] count;
  logic              doWrite;
  logic              doPop;

  function automatic logic [PtrW-1:0] incPtr(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(Depth - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  // A write into a full FIFO is dropped; the sender is expected to watch full.
  assign doWrite = wrEn && !full;
  assign doPop   = grant && req;

  assign full = (count == CountW'(Depth));
  assign req  = (count != '0);

  assign headFlitId = idMem[rdPtr];
  assign headLength = lengthMem[rdPtr];
  assign headData   = dataMem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (doWrite)
    begin
      idMem[wrPtr]     <= wrFlitId;
      lengthMem[wrPtr] <= wrLength;
      dataMem[wrPtr]   <= wrData;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doWrite)
        wrPtr <= incPtr(wrPtr);
      if (doPop)
        rdPtr <= incPtr(rdPtr);
      // Simultaneous write and pop leave the occupancy unchanged.
      case ({doWrite, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ##########################################################
  // Protocol checks

  // The sender has no handshake and must hold off while full is high.
  noWriteWhenFull: assert property (@(posedge clk) disable iff (rst) wrEn |-> !full)
    else $error("inputPort: write strobe while the FIFO is full");

  // The arbiter must only grant a port whose FIFO holds a flit.
  noGrantWhenEmpty: assert property (@(posedge clk) disable iff (rst) grant |-> req)
    else $error("inputPort: grant while the FIFO is empty");

endmodule

// File: rtl/grantTimer.sv
`timescale 1ns/1ns

module grantTimer (
  input  logic                  clk,
  input  logic                  rst,
  input  routerPkg::flitLengthT loadLength,
  input  logic                  load,
  input  logic                  run,
  output logic                  timesUp
);

  routerPkg::flitLengthT budget;
  routerPkg::flitLengthT count;
  routerPkg::flitLengthT countNext;

  // Flits sent in this grant, the one leaving in the current cycle included.
  assign countNext = count + 1'b1;

  // High during the cycle that sends the last flit of the budget.
  assign timesUp = (countNext >= budget);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      budget <= '0;
      count  <= '0;
    end
    else
    begin
      if (load)
        budget <= loadLength;
      // The count holds once the budget is spent so it cannot wrap back under it.
      if (!run)
        count <= '0;
      else if (!timesUp)
        count <= countNext;
    end
  end

endmodule

// File: rtl/outputArbiter.sv
`timescale 1ns/1ns
`include "router_defs.svh"

module outputArbiter (
  input  logic                  clk,
  input  logic                  rst,
  input  routerPkg::portMaskT   req,
  input  routerPkg::flitIdT     headFlitId0,
  input  routerPkg::flitIdT     headFlitId1,
  input  routerPkg::flitIdT     headFlitId2,
  input  routerPkg::flitIdT     headFlitId3,
  input  routerPkg::flitIdT     headFlitId4,
  input  routerPkg::flitLengthT headLength0,
  input  routerPkg::flitLengthT headLength1,
  input  routerPkg::flitLengthT headLength2,
  input  routerPkg::flitLengthT headLength3,
  input  routerPkg::flitLengthT headLength4,
  output routerPkg::portMaskT   grant
);

  localparam int NumPorts = `ROUTER_NUM_PORTS;
  localparam routerPkg::flitIdT HeaderId = routerPkg::flitIdT'(1);

  routerPkg::arbStateT   state;
  routerPkg::arbStateT   nextState;
  routerPkg::flitIdT     headFlitId [NumPorts];
  routerPkg::flitLengthT headLength [NumPorts];
  routerPkg::portMaskT   served;
  routerPkg::portMaskT   nextMask;
  routerPkg::portMaskT   timesUp;
  routerPkg::portMaskT   timerLoad;
  routerPkg::portIdxT    curIdx;

  assign headFlitId = '{headFlitId0, headFlitId1, headFlitId2, headFlitId3, headFlitId4};
  assign headLength = '{headLength0, headLength1, headLength2, headLength3, headLength4};

  // Port bits of the one-hot state; all zero in idle.
  assign served = state[NumPorts:1];
  assign grant  = served & req;

  // Idle behaves as if S had just been served, so the search starts at L.
  always_comb
  begin
    curIdx = routerPkg::portIdxT'(NumPorts - 1);
    for (int i = 0; i < NumPorts; i++)
    begin
      if (served[i])
        curIdx = routerPkg::portIdxT'(i);
    end
  end

  // ##########################################################
  // Next state with rotating priority

  always_comb
  begin
    int idx;
    idx = 0;
    nextMask = '0;
    if (|(grant & ~timesUp))
      nextMask = served;
    else
    begin
      // Walk from the farthest port to the nearest so the nearest requester wins.
      // The current port comes last, which lets a lone port keep the link.
      for (int off = NumPorts; off >= 1; off--)
      begin
        idx = (int'(curIdx) + off) % NumPorts;
        if (req[idx])
          nextMask = routerPkg::portMaskT'(1) << idx;
      end
    end
    if (nextMask == '0)
      nextState = routerPkg::idle;
    else
      nextState = routerPkg::arbStateT'({nextMask, 1'b0});
  end

  // A timer reloads only when its port is newly entered with a header at the head.
  always_comb
  begin
    for (int i = 0; i < NumPorts; i++)
      timerLoad[i] = nextMask[i] && !served[i] && (headFlitId[i] == HeaderId);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= routerPkg::idle;
    else
      state <= nextState;
  end

  for (genvar p = 0; p < NumPorts; p++)
  begin : genTimer
    grantTimer i_timer (
      .clk        (clk),
      .rst        (rst),
      .loadLength (headLength[p]),
      .load       (timerLoad[p]),
      .run        (grant[p]),
      .timesUp    (timesUp[p])
    );
  end

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("outputArbiter: more than one port granted");

endmodule

// File: rtl/outputStage.sv
`timescale 1ns/1ns
`include "router_defs.svh"

module outputStage (
  input  logic                clk,
  input  logic                rst,
  input  routerPkg::portMaskT grant,
  input  routerPkg::flitIdT   headFlitId0,
  input  routerPkg::flitIdT   headFlitId1,
  input  routerPkg::flitIdT   headFlitId2,
  input  routerPkg::flitIdT   headFlitId3,
  input  routerPkg::flitIdT   headFlitId4,
  input  routerPkg::flitDataT headData0,
  input  routerPkg::flitDataT headData1,
  input  routerPkg::flitDataT headData2,
  input  routerPkg::flitDataT headData3,
  input  routerPkg::flitDataT headData4,
  output logic                linkValid,
  output routerPkg::portIdxT  linkPort,
  output routerPkg::flitIdT   linkFlitId,
  output routerPkg::flitDataT linkData
);

  localparam int NumPorts = `ROUTER_NUM_PORTS;

  routerPkg::flitIdT   headFlitId [NumPorts];
  routerPkg::flitDataT headData   [NumPorts];
  routerPkg::portIdxT  selIdx;
  routerPkg::flitIdT   selFlitId;
  routerPkg::flitDataT selData;

  assign headFlitId = '{headFlitId0, headFlitId1, headFlitId2, headFlitId3, headFlitId4};
  assign headData   = '{headData0, headData1, headData2, headData3, headData4};

  // Grant is one-hot, so the last match is the only match.
  always_comb
  begin
    selIdx    = '0;
    selFlitId = headFlitId[0];
    selData   = headData[0];
    for (int i = 0; i < NumPorts; i++)
    begin
      if (grant[i])
      begin
        selIdx    = routerPkg::portIdxT'(i);
        selFlitId = headFlitId[i];
        selData   = headData[i];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      linkValid <= 1'b0;
    else
      linkValid <= |grant;
  end

  always_ff @(posedge clk)
  begin
    if (|grant)
    begin
      linkPort   <= selIdx;
      linkFlitId <= selFlitId;
      linkData   <= selData;
    end
  end

endmodule

// File: rtl/outputLinkTop.sv
`timescale 1ns/1ns

module outputLinkTop (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wrEn0,
  input  routerPkg::flitIdT     wrFlitId0,
  input  routerPkg::flitLengthT wrLength0,
  input  routerPkg::flitDataT   wrData0,
  input  logic                  wrEn1,
  input  routerPkg::flitIdT     wrFlitId1,
  input  routerPkg::flitLengthT wrLength1,
  input  routerPkg::flitDataT   wrData1,
  input  logic                  wrEn2,
  input  routerPkg::flitIdT     wrFlitId2,
  input  routerPkg::flitLengthT wrLength2,
  input  routerPkg::flitDataT   wrData2,
  input  logic                  wrEn3,
  input  routerPkg::flitIdT     wrFlitId3,
  input  routerPkg::flitLengthT wrLength3,
  input  routerPkg::flitDataT   wrData3,
  input  logic                  wrEn4,
  input  routerPkg::flitIdT     wrFlitId4,
  input  routerPkg::flitLengthT wrLength4,
  input  routerPkg::flitDataT   wrData4,
  output logic                  full0,
  output logic                  full1,
  output logic                  full2,
  output logic                  full3,
  output logic                  full4,
  output logic                  linkValid,
  output routerPkg::portIdxT    linkPort,
  output routerPkg::flitIdT     linkFlitId,
  output routerPkg::flitDataT   linkData
);

  routerPkg::portMaskT   req;
  routerPkg::portMaskT   grant;
  routerPkg::flitIdT     headFlitId0, headFlitId1, headFlitId2, headFlitId3, headFlitId4;
  routerPkg::flitLengthT headLength0, headLength1, headLength2, headLength3, headLength4;
  routerPkg::flitDataT   headData0, headData1, headData2, headData3, headData4;

  // ##########################################################
  // Input ports L, N, E, W, S

  inputPort i_portL (.clk(clk), .rst(rst), .wrEn(wrEn0), .wrFlitId(wrFlitId0),
    .wrLength(wrLength0), .wrData(wrData0), .grant(grant[0]), .full(full0), .req(req[0]),
    .headFlitId(headFlitId0), .headLength(headLength0), .headData(headData0));

  inputPort i_portN (.clk(clk), .rst(rst), .wrEn(wrEn1), .wrFlitId(wrFlitId1),
    .wrLength(wrLength1), .wrData(wrData1), .grant(grant[1]), .full(full1), .req(req[1]),
    .headFlitId(headFlitId1), .headLength(headLength1), .headData(headData1));

  inputPort i_portE (.clk(clk), .rst(rst), .wrEn(wrEn2), .wrFlitId(wrFlitId2),
    .wrLength(wrLength2), .wrData(wrData2), .grant(grant[2]), .full(full2), .req(req[2]),
    .headFlitId(headFlitId2), .headLength(headLength2), .headData(headData2));

  inputPort i_portW (.clk(clk), .rst(rst), .wrEn(wrEn3), .wrFlitId(wrFlitId3),
    .wrLength(wrLength3), .wrData(wrData3), .grant(grant[3]), .full(full3), .req(req[3]),
    .headFlitId(headFlitId3), .headLength(headLength3), .headData(headData3));

  inputPort i_portS (.clk(clk), .rst(rst), .wrEn(wrEn4), .wrFlitId(wrFlitId4),
    .wrLength(wrLength4), .wrData(wrData4), .grant(grant[4]), .full(full4), .req(req[4]),
    .headFlitId(headFlitId4), .headLength(headLength4), .headData(headData4));

  // ##########################################################
  // Arbitration and link register

  outputArbiter i_arbiter (.clk(clk), .rst(rst), .req(req),
    .headFlitId0(headFlitId0), .headFlitId1(headFlitId1), .headFlitId2(headFlitId2),
    .headFlitId3(headFlitId3), .headFlitId4(headFlitId4),
    .headLength0(headLength0), .headLength1(headLength1), .headLength2(headLength2),
    .headLength3(headLength3), .headLength4(headLength4), .grant(grant));

  outputStage i_stage (.clk(clk), .rst(rst), .grant(grant),
    .headFlitId0(headFlitId0), .headFlitId1(headFlitId1), .headFlitId2(headFlitId2),
    .headFlitId3(headFlitId3), .headFlitId4(headFlitId4),
    .headData0(headData0), .headData1(headData1), .headData2(headData2),
    .headData3(headData3), .headData4(headData4),
    .linkValid(linkValid), .linkPort(linkPort), .linkFlitId(linkFlitId), .linkData(linkData));

endmodule

// File: bench/outputLinkTb.sv
`timescale 1ns/1ns
`include "router_defs.svh"

module outputLinkTb;

  localparam int NumPorts = `ROUTER_NUM_PORTS;
  localparam int Depth = `ROUTER_FIFO_DEPTH;
  localparam int ResetCycles = 10;
  localparam int RandomCycles = 80;
  // Random traffic, the five-port preload and the lone-port packet.
  localparam int MaxFlits = RandomCycles * NumPorts + 2 * NumPorts * Depth;
  // Each flit costs at most one link cycle plus one bubble.
  localparam int TimeoutCycles = ResetCycles + RandomCycles + 2 * MaxFlits + 100;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  wrEn [NumPorts];
  routerPkg::flitIdT     wrFlitId [NumPorts];
  routerPkg::flitLengthT wrLength [NumPorts];
  routerPkg::flitDataT   wrData [NumPorts];
  logic [NumPorts-1:0]   full;
  logic                  linkValid;
  routerPkg::portIdxT    linkPort;
  routerPkg::flitIdT     linkFlitId;
  routerPkg::flitDataT   linkData;

  // Expected flits per port, packed as {id, length, data}.
  logic [30:0] expFlit [NumPorts][$];
  logic [31:0] lfsrState = 32'h8be7;
  string       testName;
  int          cycleCount = 0;
  int          flitsWritten = 0;
  int          flitsSeen = 0;
  logic        orderCheck = 1'b0;
  logic        checkFull = 1'b0;
  logic        prevValid = 1'b0;
  int          prevSource;
  int          runLen;
  int          pktLeft [NumPorts];
  int          budget [NumPorts];

  always #2 clk = ~clk;

  outputLinkTop i_dut (.clk(clk), .rst(rst),
    .wrEn0(wrEn[0]), .wrFlitId0(wrFlitId[0]), .wrLength0(wrLength[0]), .wrData0(wrData[0]),
    .wrEn1(wrEn[1]), .wrFlitId1(wrFlitId[1]), .wrLength1(wrLength[1]), .wrData1(wrData[1]),
    .wrEn2(wrEn[2]), .wrFlitId2(wrFlitId[2]), .wrLength2(wrLength[2]), .wrData2(wrData[2]),
    .wrEn3(wrEn[3]), .wrFlitId3(wrFlitId[3]), .wrLength3(wrLength[3]), .wrData3(wrData[3]),
    .wrEn4(wrEn[4]), .wrFlitId4(wrFlitId[4]), .wrLength4(wrLength[4]), .wrData4(wrData[4]),
    .full0(full[0]), .full1(full[1]), .full2(full[2]), .full3(full[3]), .full4(full[4]),
    .linkValid(linkValid), .linkPort(linkPort), .linkFlitId(linkFlitId), .linkData(linkData));

  // ############################################################
  // Helpers

  task automatic reportFailure(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic checkValue(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected)
      reportFailure($sformatf("[ERROR] %s, %s: expected %0h, actual %0h",
                              testName, what, expected, actual));
  endtask

  // Fibonacci LFSR with taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic drawBits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsrState = lfsrStep(lfsrState);
      bits = {bits[30:0], lfsrState[0]};
    end
  endtask

  // Nearest port after prev in the order L, N, E, W, S; prev itself comes last.
  function automatic int nextPort(input int prev, input logic [NumPorts-1:0] pending);
    int cand;
    for (int off = 1; off <= NumPorts; off++)
    begin
      cand = (prev + off) % NumPorts;
      if (pending[cand])
        return cand;
    end
    return -1;
  endfunction

  function automatic logic [NumPorts-1:0] pendingMask();
    logic [NumPorts-1:0] mask;
    for (int p = 0; p < NumPorts; p++)
      mask[p] = (expFlit[p].size() != 0);
    return mask;
  endfunction

  // A packet is a header carrying the budget, then body flits and a tail.
  task automatic sendFlit(input int p, input int pktFlits, input int budgetLen);
    logic [31:0]           bits;
    routerPkg::flitIdT     id;
    routerPkg::flitLengthT len;
    drawBits(16, bits);
    len = '0;
    if (pktLeft[p] == 0)
    begin
      id = routerPkg::flitIdT'(1);
      len = routerPkg::flitLengthT'(budgetLen);
      pktLeft[p] = pktFlits - 1;
    end
    else
    begin
      id = (pktLeft[p] == 1) ? routerPkg::flitIdT'(3) : routerPkg::flitIdT'(2);
      pktLeft[p] = pktLeft[p] - 1;
    end
    wrEn[p] <= 1'b1;
    wrFlitId[p] <= id;
    wrLength[p] <= len;
    wrData[p] <= bits[15:0];
    expFlit[p].push_back({id, len, bits[15:0]});
    flitsWritten++;
  endtask

  task automatic stopWrites();
    @(posedge clk);
    for (int p = 0; p < NumPorts; p++)
      wrEn[p] <= 1'b0;
  endtask

  task automatic waitDrain();
    while (pendingMask() != '0)
      @(posedge clk);
    repeat (3) @(posedge clk);
  endtask

  // ############################################################
  // Comparison against the expected queues

  always @(negedge clk)
  begin
    int                  q;
    logic [30:0]         want;
    logic [NumPorts-1:0] pending;
    pending = pendingMask();
    if (rst)
    begin
      if (cycleCount > 0)
        checkValue("linkValid during reset", 0, linkValid);
    end
    else if (linkValid !== 1'b1)
      checkValue("linkValid", 0, linkValid);
    else if (linkPort >= NumPorts || !pending[linkPort])
      reportFailure($sformatf("A flit left the link from port %0d with no flit pending there.",
                              linkPort));
    else
    begin
      q = int'(linkPort);
      want = expFlit[q].pop_front();
      checkValue($sformatf("flit id from port %0d", q), want[30:28], linkFlitId);
      checkValue($sformatf("flit data from port %0d", q), want[15:0], linkData);
      if (checkFull)
        checkValue($sformatf("full level of port %0d after its grant", q), 0, full[q]);
      if (orderCheck)
      begin
        // A bubble on the link ends a run.
        if (runLen == 0 || q != prevSource || !prevValid)
        begin
          checkValue("source port after rotation", nextPort(prevSource, pending), q);
          runLen = 1;
        end
        else
        begin
          runLen++;
          if (runLen > budget[q] && (pending & ~(1 << q)) != '0)
            reportFailure($sformatf("Port %0d sent %0d flits in a row on a budget of %0d.",
                                    q, runLen, budget[q]));
        end
        prevSource = q;
      end
      if (want[30:28] == 3'd1)
        budget[q] = want[27:16];
      flitsSeen++;
    end
    prevValid = (linkValid === 1'b1);
  end

  always @(posedge clk)
  begin
    cycleCount = cycleCount + 1;
    if (cycleCount > TimeoutCycles)
      reportFailure("The run timed out before the link drained.");
  end

  // ############################################################
  // Stimulus

  initial
  begin
    logic [31:0] bits;
    rst = 1'b1;
    for (int p = 0; p < NumPorts; p++)
    begin
      wrEn[p] = 1'b0;
      wrFlitId[p] = '0;
      wrLength[p] = '0;
      wrData[p] = '0;
      pktLeft[p] = 0;
      budget[p] = 0;
    end
    testName = "reset";
    repeat (ResetCycles) @(posedge clk);
    rst <= 1'b0;
    testName = "idle link";
    repeat (5) @(posedge clk);

    // The sender stays below the depth so it never writes into a full FIFO.
    testName = "random traffic";
    for (int c = 0; c < RandomCycles; c++)
    begin
      @(posedge clk);
      for (int p = 0; p < NumPorts; p++)
      begin
        drawBits(2, bits);
        if (bits[1:0] == 2'd0 && expFlit[p].size() < Depth)
        begin
          drawBits(2, bits);
          sendFlit(p, bits + 1, bits + 1);
        end
        else
          wrEn[p] <= 1'b0;
      end
    end
    stopWrites();
    waitDrain();

    // All five ports fill together while L holds the link.
    testName = "preload of all ports";
    prevSource = NumPorts - 1;
    runLen = 0;
    orderCheck = 1'b1;
    for (int p = 0; p < NumPorts; p++)
      pktLeft[p] = 0;
    for (int k = 0; k < Depth; k++)
    begin
      @(posedge clk);
      for (int p = 0; p < NumPorts; p++)
      begin
        drawBits(2, bits);
        sendFlit(p, Depth, bits + 2);
      end
    end
    stopWrites();
    @(negedge clk);
    checkValue("full levels of N, E, W and S", 4'b1111, full[4:1]);
    @(posedge clk);
    checkFull = 1'b1;
    waitDrain();
    checkFull = 1'b0;

    // A lone port keeps the link past a budget of one.
    testName = "lone port";
    prevSource = NumPorts - 1;
    runLen = 0;
    for (int k = 0; k < Depth; k++)
    begin
      @(posedge clk);
      sendFlit(2, Depth, 1);
    end
    stopWrites();
    waitDrain();
    checkValue("consecutive flits from the lone port", Depth, runLen);
    orderCheck = 1'b0;

    checkValue("flits sent on the link", flitsWritten, flitsSeen);
    $display("All tests passed");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+rtl
rtl/routerPkg.sv
rtl/inputPort.sv
rtl/grantTimer.sv
rtl/outputArbiter.sv
rtl/outputStage.sv
rtl/outputLinkTop.sv
bench/outputLinkTb.sv

// File: Bender.yml
package:
  name: output_link

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/routerPkg.sv
      - rtl/inputPort.sv
      - rtl/grantTimer.sv
      - rtl/outputArbiter.sv
      - rtl/outputStage.sv
      - rtl/outputLinkTop.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/outputLinkTb.sv
